// File: Makefile
.PHONY: all build lint clean

all: build
	./obj_dir/Vtb_trace_debugger | tee /dev/stderr | grep -qF '*** PASSED ***'

build:
	verilator --binary --timing -f filelist.f --top-module tb_trace_debugger \
		-o Vtb_trace_debugger

lint:
	verilator --lint-only --timing -f filelist.f --top-module trace_debugger

clean:
	rm -rf obj_dir

// File: bench/tb_trace_debugger.sv
// random trace sessions against a cycle model of the nc/tc/lc rules
// resync limit is lowered to 24, every packet also checks the 2 cycle latency
`timescale 1ns/1ps

module tb_trace_debugger import trdb_pkg::*; ();

    localparam int unsigned RESYNC = 24;

    typedef struct packed {
        logic                 v;
        logic                 on;
        logic [XLEN-1:0]      pc;
        logic [INST_LEN-1:0]  inst;
        logic [PRIV_LEN-1:0]  priv;
        logic                 exc;
        logic                 intr;
        logic [CAUSE_LEN-1:0] cause;
        int                   cyc;
    } trace_entry_t;

    logic                   clk_i = 1'b0;
    logic                   rst_ni = 1'b0;
    logic                   inst_valid_i = 1'b0;
    logic                   trace_on_i = 1'b0;
    logic [XLEN-1:0]        pc_i = '0;
    logic [INST_LEN-1:0]    inst_data_i = '0;
    logic [PRIV_LEN-1:0]    priv_lvl_i = '0;
    logic                   exception_i = 1'b0;
    logic                   interrupt_i = 1'b0;
    logic [CAUSE_LEN-1:0]   cause_i = '0;
    logic                   packet_valid_o;
    it_packet_type_e        packet_type_o;
    logic [P_LEN-1:0]       packet_length_o;
    logic [PAYLOAD_LEN-1:0] packet_payload_o;

    // model state
    trace_entry_t           lc_e = '0, tc_e = '0, nc_e = '0;
    logic [30:0]            ref_map = '0;
    int                     ref_count = 0;
    int                     ref_resync = 0;
    int                     cycle = 0;
    logic [15:0]            lfsr = 16'd73;
    logic [XLEN-1:0]        cur_pc = 32'h0000_1000;
    logic [PRIV_LEN-1:0]    cur_priv = 2'd3;
    it_packet_type_e        exp_type[$];
    logic [P_LEN-1:0]       exp_len[$];
    logic [PAYLOAD_LEN-1:0] exp_payload[$];
    int                     exp_cyc[$];

    trace_debugger #(.RESYNC_MAX(RESYNC)) i_trace_debugger (.*);

    always #4 clk_i = ~clk_i;

    always @(posedge clk_i) cycle <= cycle + 1;

    // galois lfsr, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val[i] = lfsr[0];
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        end
        return val;
    endfunction

    task automatic stop_with_fail(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [71:0] got,
                               input logic [71:0] exp);
        if (got !== exp) begin
            stop_with_fail($sformatf("Mismatch %s: got 0x%0h expected 0x%0h",
                                     name, got, exp));
        end
    endtask

    // reference rules for one lc/tc/nc view, updates model map and resync
    function automatic void predict_packet(input trace_entry_t lc, input trace_entry_t tc,
                                           input trace_entry_t nc);
        logic                   tc_q, lc_q, nc_q, br, nt, push, lc_upd, due;
        logic [6:0]             lc_op;
        logic [30:0]            post_map;
        int                     post_cnt;
        it_packet_type_e        kind;
        logic [PAYLOAD_LEN-1:0] pl;
        logic [P_LEN-1:0]       len;
        tc_q  = tc.v && tc.on;
        lc_q  = lc.v && lc.on;
        nc_q  = nc.v && nc.on;
        lc_op = lc.inst[6:0];
        lc_upd = lc_q && (lc_op == OPC_JALR || lc.inst == INST_MRET || lc.inst == INST_SRET);
        br    = tc.v && (tc.inst[6:0] == OPC_BRANCH);
        // fall-through pc or no next instruction means not taken
        nt    = br && (!nc.v || nc.pc == tc.pc + 32'd4);
        push  = tc_q && br;
        due   = (ref_resync >= RESYNC);
        post_cnt = ref_count + int'(push);
        post_map = ref_map;
        if (push && ref_count < 31)
            post_map[ref_count] = nt;
        kind = PKT_NONE;
        if (!tc_q)
            kind = PKT_NONE;
        else if (lc_q && lc.exc)
            kind = PKT_SYNC_TRAP;
        else if (!lc_q || (tc.priv != lc.priv) || due)
            kind = PKT_SYNC_START;
        else if (lc_upd || !nc_q)
            kind = (post_cnt != 0) ? PKT_BRANCH_ADDR : PKT_ADDR;
        else if (post_cnt == 31)
            kind = PKT_BRANCH_FULL;
        pl  = '0;
        len = '0;
        case (kind)
            PKT_BRANCH_FULL, PKT_BRANCH_ADDR: begin
                pl[OFS_COUNT +: BRANCH_COUNT_LEN] = BRANCH_COUNT_LEN'(post_cnt);
                pl[OFS_MAP +: BRANCH_MAP_LEN]     = post_map;
                len = 4'd5;
                if (kind == PKT_BRANCH_ADDR) begin
                    pl[OFS_ADDR_BR +: XLEN] = tc.pc;
                    len = 4'd9;
                end
            end
            PKT_ADDR: begin
                pl[XLEN-1:0] = tc.pc;
                len = 4'd4;
            end
            PKT_SYNC_START: begin
                pl[OFS_BRANCH]                  = nt;
                pl[OFS_PRIV +: PRIV_LEN]        = tc.priv;
                pl[OFS_ADDR_SYNC_START +: XLEN] = tc.pc;
                len = 4'd5;
            end
            PKT_SYNC_TRAP: begin
                pl[OFS_BRANCH]                 = nt;
                pl[OFS_PRIV +: PRIV_LEN]       = tc.priv;
                pl[OFS_INTR]                   = lc.intr;
                pl[OFS_CAUSE +: CAUSE_LEN]     = lc.cause;
                pl[OFS_ADDR_SYNC_TRAP +: XLEN] = tc.pc;
                len = 4'd6;
            end
            default: pl = '0;
        endcase
        // any packet empties the map
        if (kind != PKT_NONE) begin
            ref_map   = '0;
            ref_count = 0;
            exp_type.push_back(kind);
            exp_len.push_back(len);
            exp_payload.push_back(pl);
            // sampled one edge after being driven, packet 2 edges later
            exp_cyc.push_back(tc.cyc + 2);
        end else if (push && ref_count < 31) begin
            ref_map   = post_map;
            ref_count = post_cnt;
        end
        if (kind == PKT_SYNC_START || kind == PKT_SYNC_TRAP || !tc_q)
            ref_resync = 0;
        else if (ref_resync < RESYNC)
            ref_resync++;
    endfunction

    // one cycle of input, shifts the model stages
    task automatic drive_cycle(input trace_entry_t e);
        @(posedge clk_i);
        inst_valid_i <= e.v;
        trace_on_i   <= e.on;
        pc_i         <= e.pc;
        inst_data_i  <= e.inst;
        priv_lvl_i   <= e.priv;
        exception_i  <= e.exc;
        interrupt_i  <= e.intr;
        cause_i      <= e.cause;
        e.cyc = cycle;
        lc_e = tc_e;
        tc_e = nc_e;
        nc_e = e;
        predict_packet(lc_e, tc_e, nc_e);
    endtask

    // kind 0 plain, 1 branch, 2 jalr, 3 mret, 4 sret, 5 exception
    task automatic retire(input int kind, input logic on);
        trace_entry_t e;
        logic [XLEN-1:0] next_pc;
        e = '0;
        e.v = 1'b1;
        e.on = on;
        e.pc = cur_pc;
        e.priv = cur_priv;
        e.inst = 32'h0000_0013;
        next_pc = cur_pc + 32'd4;
        case (kind)
            1: begin
                e.inst = 32'h0000_0063;
                if (rand_bits(1))
                    next_pc = cur_pc + 32'd8 + (rand_bits(4) << 2);
            end
            2: begin
                e.inst = 32'h0000_80e7;
                next_pc = 32'h0000_4000 + (rand_bits(8) << 2);
            end
            3, 4: begin
                e.inst = (kind == 3) ? INST_MRET : INST_SRET;
                next_pc = 32'h0000_8000 + (rand_bits(8) << 2);
            end
            5: begin
                e.exc = 1'b1;
                e.intr = 1'(rand_bits(1));
                e.cause = CAUSE_LEN'(rand_bits(5));
                // handler entry depends on cause
                next_pc = 32'h0000_0100 + XLEN'({e.cause, 2'b00});
            end
            default: e.inst = 32'h0000_0013;
        endcase
        drive_cycle(e);
        cur_pc = next_pc;
    endtask

    // mixed session, always closed by a plain instruction
    task automatic random_session(input int len);
        int pick;
        for (int i = 0; i < len; i++) begin
            if (rand_bits(4) == 0)
                cur_priv = PRIV_LEN'(rand_bits(2));
            pick = rand_bits(3);
            if (pick < 3)
                retire(0, 1'b1);
            else if (pick < 5)
                retire(1, 1'b1);
            else if (pick == 5)
                retire(2, 1'b1);
            else if (pick == 6)
                retire(rand_bits(1) ? 3 : 4, 1'b1);
            else
                retire(5, 1'b1);
        end
        retire(0, 1'b1);
    endtask

    // untraced instructions and idle cycles
    task automatic quiet_gap(input int len);
        for (int i = 0; i < len; i++) begin
            if (rand_bits(1))
                retire(rand_bits(1), 1'b0);
            else
                drive_cycle('0);
        end
    endtask

    always @(negedge clk_i) begin
        if (rst_ni && packet_valid_o) begin
            if (exp_type.size() == 0)
                stop_with_fail("packet emitted while none was expected");
            check_value("packet_type_o", 72'(packet_type_o), 72'(exp_type.pop_front()));
            check_value("packet_length_o", 72'(packet_length_o), 72'(exp_len.pop_front()));
            check_value("packet_payload_o", packet_payload_o, exp_payload.pop_front());
            check_value("latency", 72'(cycle - exp_cyc.pop_front()), 72'(2));
        end
    end

    initial begin
        int t;
        repeat (16) @(posedge clk_i);
        rst_ni <= 1'b1;
        quiet_gap(3);
        // long branch run fills the map
        for (int i = 0; i < 40; i++)
            retire(1, 1'b1);
        retire(0, 1'b1);
        quiet_gap(4);
        // quiet run forces periodic resync
        for (int i = 0; i < 60; i++)
            retire(0, 1'b1);
        quiet_gap(4);
        // branches then a jump, address packet with pending map
        retire(1, 1'b1);
        retire(1, 1'b1);
        retire(2, 1'b1);
        retire(0, 1'b1);
        retire(3, 1'b1);
        retire(0, 1'b1);
        quiet_gap(2);
        for (int s = 0; s < 14; s++) begin
            random_session(8 + rand_bits(5));
            quiet_gap(1 + rand_bits(3));
        end
        // directed short session, final address packet latency
        retire(0, 1'b1);
        retire(0, 1'b1);
        retire(0, 1'b1);
        quiet_gap(6);
        for (t = 0; t < 200 && exp_type.size() != 0; t++)
            @(posedge clk_i);
        if (exp_type.size() != 0) begin
            stop_with_fail("expected packets never arrived before the timeout");
        end else begin
            $display("*** PASSED ***");
            $finish;
        end
    end

endmodule

// File: filelist.f
hw/trdb_pkg.sv
hw/trdb_stage_pipe.sv
hw/trdb_itype_detector.sv
hw/trdb_branch_map.sv
hw/trdb_resync_counter.sv
hw/trdb_priority.sv
hw/trdb_packet_emitter.sv
hw/trace_debugger.sv
bench/tb_trace_debugger.sv

// File: hw/trace_debugger.sv
// instruction trace encoder, fixed 2 cycle latency from sample to packet
// no handshake, packets leave as one-cycle strobes
`timescale 1ns/1ps

module trace_debugger import trdb_pkg::*; #(
    parameter int unsigned RESYNC_MAX = 64
) (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   inst_valid_i,
    input  logic                   trace_on_i,
    input  logic [XLEN-1:0]        pc_i,
    input  logic [INST_LEN-1:0]    inst_data_i,
    input  logic [PRIV_LEN-1:0]    priv_lvl_i,
    input  logic                   exception_i,
    input  logic                   interrupt_i,
    input  logic [CAUSE_LEN-1:0]   cause_i,
    output logic                   packet_valid_o,
    output it_packet_type_e        packet_type_o,
    output logic [P_LEN-1:0]       packet_length_o,
    output logic [PAYLOAD_LEN-1:0] packet_payload_o
);

    // nc view
    logic                        nc_valid, nc_updiscon;
    logic [XLEN-1:0]             nc_pc;
    logic [INST_LEN-1:0]         nc_inst;
    // tc view
    logic                        tc_qualified, tc_branch, tc_not_taken;
    logic [XLEN-1:0]             tc_pc;
    logic [PRIV_LEN-1:0]         tc_priv;
    // lc view
    logic [CAUSE_LEN-1:0]        lc_cause;
    logic                        lc_interrupt, lc_exception, lc_updiscon;
    // decision inputs
    logic                        first_qualified, final_qualified, privchange;
    logic                        resync_due;
    logic [BRANCH_MAP_LEN-1:0]   map, post_map;
    logic [BRANCH_COUNT_LEN-1:0] count, post_count;
    // decision outputs
    it_packet_type_e             packet_type;
    logic                        flush, push, sync_sent;

    trdb_stage_pipe i_trdb_stage_pipe (
        .clk_i, .rst_ni, .inst_valid_i, .trace_on_i, .pc_i, .inst_data_i,
        .priv_lvl_i, .exception_i, .interrupt_i, .cause_i,
        .nc_updiscon_i    (nc_updiscon),
        .nc_valid_o       (nc_valid),
        .nc_pc_o          (nc_pc),
        .nc_inst_o        (nc_inst),
        .tc_qualified_o   (tc_qualified),
        .tc_pc_o          (tc_pc),
        .tc_priv_o        (tc_priv),
        .lc_cause_o       (lc_cause),
        .lc_interrupt_o   (lc_interrupt),
        .first_qualified_o(first_qualified),
        .final_qualified_o(final_qualified),
        .privchange_o     (privchange),
        .lc_exception_o   (lc_exception),
        .lc_updiscon_o    (lc_updiscon)
    );

    trdb_itype_detector i_trdb_itype_detector (
        .clk_i, .rst_ni,
        .nc_valid_i    (nc_valid),
        .nc_inst_i     (nc_inst),
        .nc_pc_i       (nc_pc),
        .tc_pc_i       (tc_pc),
        .nc_updiscon_o (nc_updiscon),
        .tc_branch_o   (tc_branch),
        .tc_not_taken_o(tc_not_taken)
    );

    trdb_branch_map i_trdb_branch_map (
        .clk_i, .rst_ni,
        .push_i     (push),
        .not_taken_i(tc_not_taken),
        .flush_i    (flush),
        .map_o      (map),
        .count_o    (count)
    );

    trdb_resync_counter #(
        .RESYNC_MAX(RESYNC_MAX)
    ) i_trdb_resync_counter (
        .clk_i, .rst_ni,
        .tc_qualified_i(tc_qualified),
        .sync_sent_i   (sync_sent),
        .resync_due_o  (resync_due)
    );

    trdb_priority i_trdb_priority (
        .tc_qualified_i   (tc_qualified),
        .tc_branch_i      (tc_branch),
        .tc_not_taken_i   (tc_not_taken),
        .map_i            (map),
        .count_i          (count),
        .first_qualified_i(first_qualified),
        .final_qualified_i(final_qualified),
        .privchange_i     (privchange),
        .lc_exception_i   (lc_exception),
        .lc_updiscon_i    (lc_updiscon),
        .resync_due_i     (resync_due),
        .packet_type_o    (packet_type),
        .post_map_o       (post_map),
        .post_count_o     (post_count),
        .flush_o          (flush),
        .push_o           (push),
        .sync_sent_o      (sync_sent)
    );

    trdb_packet_emitter i_trdb_packet_emitter (
        .clk_i, .rst_ni,
        .packet_type_i (packet_type),
        .post_map_i    (post_map),
        .post_count_i  (post_count),
        .tc_pc_i       (tc_pc),
        .tc_priv_i     (tc_priv),
        .tc_branch_i   (tc_branch),
        .tc_not_taken_i(tc_not_taken),
        .lc_cause_i    (lc_cause),
        .lc_interrupt_i(lc_interrupt),
        .packet_valid_o, .packet_type_o, .packet_length_o, .packet_payload_o
    );

endmodule

// File: hw/trdb_branch_map.sv
// branch outcome store, oldest branch in bit 0
// flush wins over push, the pushed bit is already in the packet
`timescale 1ns/1ps

module trdb_branch_map import trdb_pkg::*; (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  logic                        push_i,
    input  logic                        not_taken_i,
    input  logic                        flush_i,
    output logic [BRANCH_MAP_LEN-1:0]   map_o,
    output logic [BRANCH_COUNT_LEN-1:0] count_o
);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            map_o   <= '0;
            count_o <= '0;
        end else if (flush_i) begin
            // restart empty
            map_o   <= '0;
            count_o <= '0;
        end else if (push_i) begin
            // a full map is always flushed, so count stays in range here
            if (count_o < BRANCH_COUNT_LEN'(BRANCH_MAP_LEN)) begin
                map_o[count_o] <= not_taken_i;
                count_o        <= count_o + 1'b1;
            end
        end
    end

endmodule

// File: hw/trdb_itype_detector.sv
// classifies nc by opcode, resolves the tc branch against the nc pc
// assumes 4 byte instructions when computing the fall-through pc
`timescale 1ns/1ps

module trdb_itype_detector import trdb_pkg::*; (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                nc_valid_i,
    input  logic [INST_LEN-1:0] nc_inst_i,
    input  logic [XLEN-1:0]     nc_pc_i,
    input  logic [XLEN-1:0]     tc_pc_i,
    output logic                nc_updiscon_o,
    output logic                tc_branch_o,
    output logic                tc_not_taken_o
);

    logic [6:0] opcode;
    logic       nc_branch;
    logic       nc_return;

    assign opcode    = nc_inst_i[6:0];
    assign nc_branch = nc_valid_i && (opcode == OPC_BRANCH);
    // mret and sret are the only system words that jump
    assign nc_return = (opcode == OPC_SYSTEM) &&
                       (nc_inst_i == INST_MRET || nc_inst_i == INST_SRET);
    assign nc_updiscon_o = nc_valid_i && ((opcode == OPC_JALR) || nc_return);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            tc_branch_o <= 1'b0;
        end else begin
            tc_branch_o <= nc_branch;
        end
    end

    // sequential nc pc means not taken; no nc also means not taken
    assign tc_not_taken_o = tc_branch_o &&
                            (!nc_valid_i || (nc_pc_i == tc_pc_i + XLEN'(4)));

endmodule

// File: hw/trdb_packet_emitter.sv
// packs the payload by packet kind and registers it for one cycle
// no back-pressure, valid is a single-cycle strobe
`timescale 1ns/1ps

module trdb_packet_emitter import trdb_pkg::*; (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  it_packet_type_e             packet_type_i,
    input  logic [BRANCH_MAP_LEN-1:0]   post_map_i,
    input  logic [BRANCH_COUNT_LEN-1:0] post_count_i,
    input  logic [XLEN-1:0]             tc_pc_i,
    input  logic [PRIV_LEN-1:0]         tc_priv_i,
    input  logic                        tc_branch_i,
    input  logic                        tc_not_taken_i,
    input  logic [CAUSE_LEN-1:0]        lc_cause_i,
    input  logic                        lc_interrupt_i,
    output logic                        packet_valid_o,
    output it_packet_type_e             packet_type_o,
    output logic [P_LEN-1:0]            packet_length_o,
    output logic [PAYLOAD_LEN-1:0]      packet_payload_o
);

    logic [PAYLOAD_LEN-1:0] payload_d;
    logic [P_LEN-1:0]       length_d;
    logic                   sync_branch;

    // sync branch bit set only for a not-taken tc branch
    assign sync_branch = tc_branch_i && tc_not_taken_i;

    always_comb begin
        payload_d = '0;
        length_d  = '0;
        case (packet_type_i)
            PKT_BRANCH_FULL: begin
                payload_d[OFS_COUNT +: BRANCH_COUNT_LEN] = post_count_i;
                payload_d[OFS_MAP +: BRANCH_MAP_LEN]     = post_map_i;
                // 36 bits
                length_d = P_LEN'(5);
            end
            PKT_BRANCH_ADDR: begin
                payload_d[OFS_COUNT +: BRANCH_COUNT_LEN] = post_count_i;
                payload_d[OFS_MAP +: BRANCH_MAP_LEN]     = post_map_i;
                payload_d[OFS_ADDR_BR +: XLEN]           = tc_pc_i;
                // 68 bits
                length_d = P_LEN'(9);
            end
            PKT_ADDR: begin
                payload_d[XLEN-1:0] = tc_pc_i;
                length_d = P_LEN'(4);
            end
            PKT_SYNC_START: begin
                payload_d[OFS_BRANCH]                   = sync_branch;
                payload_d[OFS_PRIV +: PRIV_LEN]         = tc_priv_i;
                payload_d[OFS_ADDR_SYNC_START +: XLEN]  = tc_pc_i;
                // 35 bits
                length_d = P_LEN'(5);
            end
            PKT_SYNC_TRAP: begin
                payload_d[OFS_BRANCH]                  = sync_branch;
                payload_d[OFS_PRIV +: PRIV_LEN]        = tc_priv_i;
                payload_d[OFS_INTR]                    = lc_interrupt_i;
                payload_d[OFS_CAUSE +: CAUSE_LEN]      = lc_cause_i;
                payload_d[OFS_ADDR_SYNC_TRAP +: XLEN]  = tc_pc_i;
                // 41 bits
                length_d = P_LEN'(6);
            end
            default: begin
                payload_d = '0;
                length_d  = '0;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            packet_valid_o <= 1'b0;
            packet_type_o  <= PKT_NONE;
        end else begin
            packet_valid_o <= (packet_type_i != PKT_NONE);
            packet_type_o  <= packet_type_i;
        end
    end

    // payload only meaningful while valid is high
    always_ff @(posedge clk_i) begin
        packet_length_o  <= length_d;
        packet_payload_o <= payload_d;
    end

endmodule

// File: hw/trdb_pkg.sv
// widths and field offsets are fixed by the packet layout
// every instruction is assumed to be 4 bytes, no compressed support
package trdb_pkg;

    localparam int unsigned XLEN             = 32;
    localparam int unsigned INST_LEN         = 32;
    localparam int unsigned PRIV_LEN         = 2;
    localparam int unsigned CAUSE_LEN        = 5;
    localparam int unsigned BRANCH_MAP_LEN   = 31;
    localparam int unsigned BRANCH_COUNT_LEN = 5;
    localparam int unsigned PAYLOAD_LEN      = 72;
    // length field counts bytes
    localparam int unsigned P_LEN            = 4;

    typedef enum logic [2:0] {
        PKT_NONE        = 3'd0,
        PKT_BRANCH_FULL = 3'd1,
        PKT_BRANCH_ADDR = 3'd2,
        PKT_ADDR        = 3'd3,
        PKT_SYNC_START  = 3'd4,
        PKT_SYNC_TRAP   = 3'd5
    } it_packet_type_e;

    // major opcodes, bits [6:0] of the instruction word
    typedef enum logic [6:0] {
        OPC_BRANCH = 7'b1100011,
        OPC_JALR   = 7'b1100111,
        OPC_SYSTEM = 7'b1110011
    } trdb_opcode_e;

    localparam logic [INST_LEN-1:0] INST_MRET = 32'h3020_0073;
    localparam logic [INST_LEN-1:0] INST_SRET = 32'h1020_0073;

    // branch packet fields
    localparam int unsigned OFS_COUNT           = 0;
    localparam int unsigned OFS_MAP             = 5;
    localparam int unsigned OFS_ADDR_BR         = 36;
    // sync packet fields
    localparam int unsigned OFS_BRANCH          = 0;
    localparam int unsigned OFS_PRIV            = 1;
    localparam int unsigned OFS_INTR            = 3;
    localparam int unsigned OFS_CAUSE           = 4;
    localparam int unsigned OFS_ADDR_SYNC_START = 3;
    localparam int unsigned OFS_ADDR_SYNC_TRAP  = 9;

endpackage

// File: hw/trdb_priority.sv
// picks at most one packet kind for the tc instruction
// also merges the tc branch bit into the map the packet reports
`timescale 1ns/1ps

module trdb_priority import trdb_pkg::*; (
    input  logic                        tc_qualified_i,
    input  logic                        tc_branch_i,
    input  logic                        tc_not_taken_i,
    input  logic [BRANCH_MAP_LEN-1:0]   map_i,
    input  logic [BRANCH_COUNT_LEN-1:0] count_i,
    input  logic                        first_qualified_i,
    input  logic                        final_qualified_i,
    input  logic                        privchange_i,
    input  logic                        lc_exception_i,
    input  logic                        lc_updiscon_i,
    input  logic                        resync_due_i,
    output it_packet_type_e             packet_type_o,
    output logic [BRANCH_MAP_LEN-1:0]   post_map_o,
    output logic [BRANCH_COUNT_LEN-1:0] post_count_o,
    output logic                        flush_o,
    output logic                        push_o,
    output logic                        sync_sent_o
);

    assign push_o       = tc_qualified_i && tc_branch_i;
    assign post_count_o = count_i + BRANCH_COUNT_LEN'(push_o);

    // tc bit lands right after the stored ones
    always_comb begin
        post_map_o = map_i;
        if (push_o && count_i < BRANCH_COUNT_LEN'(BRANCH_MAP_LEN)) begin
            post_map_o[count_i] = tc_not_taken_i;
        end
    end

    always_comb begin
        packet_type_o = PKT_NONE;
        if (!tc_qualified_i) begin
            packet_type_o = PKT_NONE;
        end else if (lc_exception_i) begin
            // tc is the trap handler entry
            packet_type_o = PKT_SYNC_TRAP;
        end else if (first_qualified_i || privchange_i || resync_due_i) begin
            packet_type_o = PKT_SYNC_START;
        end else if (lc_updiscon_i || final_qualified_i) begin
            // address packet, carries pending branches if any
            packet_type_o = (post_count_o != '0) ? PKT_BRANCH_ADDR : PKT_ADDR;
        end else if (post_count_o == BRANCH_COUNT_LEN'(BRANCH_MAP_LEN)) begin
            packet_type_o = PKT_BRANCH_FULL;
        end
    end

    // any packet empties the map, sync drops what was pending
    assign flush_o     = (packet_type_o != PKT_NONE);
    assign sync_sent_o = (packet_type_o == PKT_SYNC_START) ||
                         (packet_type_o == PKT_SYNC_TRAP);

endmodule

// File: hw/trdb_resync_counter.sv
// counts qualified instructions since the last sync packet
// saturates at RESYNC_MAX until a sync is sent
`timescale 1ns/1ps

module trdb_resync_counter #(
    parameter int unsigned RESYNC_MAX = 64
) (
    input  logic clk_i,
    input  logic rst_ni,
    input  logic tc_qualified_i,
    input  logic sync_sent_i,
    output logic resync_due_o
);

    localparam int unsigned CNT_W = $clog2(RESYNC_MAX + 1);

    logic [CNT_W-1:0] count_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            count_q <= '0;
        end else if (sync_sent_i || !tc_qualified_i) begin
            // untraced gap or fresh sync restarts the window
            count_q <= '0;
        end else if (count_q < CNT_W'(RESYNC_MAX)) begin
            count_q <= count_q + 1'b1;
        end
    end

    assign resync_due_o = (count_q >= CNT_W'(RESYNC_MAX));

endmodule

// File: hw/trdb_stage_pipe.sv
// three stage registers nc -> tc -> lc, shifting every clock
// qualification is valid and trace_on sampled together
`timescale 1ns/1ps

module trdb_stage_pipe import trdb_pkg::*; (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 inst_valid_i,
    input  logic                 trace_on_i,
    input  logic [XLEN-1:0]      pc_i,
    input  logic [INST_LEN-1:0]  inst_data_i,
    input  logic [PRIV_LEN-1:0]  priv_lvl_i,
    input  logic                 exception_i,
    input  logic                 interrupt_i,
    input  logic [CAUSE_LEN-1:0] cause_i,
    input  logic                 nc_updiscon_i,
    output logic                 nc_valid_o,
    output logic [XLEN-1:0]      nc_pc_o,
    output logic [INST_LEN-1:0]  nc_inst_o,
    output logic                 tc_qualified_o,
    output logic [XLEN-1:0]      tc_pc_o,
    output logic [PRIV_LEN-1:0]  tc_priv_o,
    output logic [CAUSE_LEN-1:0] lc_cause_o,
    output logic                 lc_interrupt_o,
    output logic                 first_qualified_o,
    output logic                 final_qualified_o,
    output logic                 privchange_o,
    output logic                 lc_exception_o,
    output logic                 lc_updiscon_o
);

    // control flags per stage
    logic nc_qual_q, tc_qual_q, lc_qual_q;
    logic nc_exc_q, tc_exc_q, lc_exc_q;
    logic tc_updiscon_q, lc_updiscon_q;
    // payload per stage
    logic [PRIV_LEN-1:0]  nc_priv_q, lc_priv_q;
    logic                 nc_intr_q, tc_intr_q;
    logic [CAUSE_LEN-1:0] nc_cause_q, tc_cause_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            nc_valid_o    <= 1'b0;
            nc_qual_q     <= 1'b0;
            tc_qual_q     <= 1'b0;
            lc_qual_q     <= 1'b0;
            nc_exc_q      <= 1'b0;
            tc_exc_q      <= 1'b0;
            lc_exc_q      <= 1'b0;
            tc_updiscon_q <= 1'b0;
            lc_updiscon_q <= 1'b0;
        end else begin
            nc_valid_o    <= inst_valid_i;
            // trace_on is a level taken with the instruction
            nc_qual_q     <= inst_valid_i && trace_on_i;
            tc_qual_q     <= nc_qual_q;
            lc_qual_q     <= tc_qual_q;
            nc_exc_q      <= inst_valid_i && exception_i;
            tc_exc_q      <= nc_exc_q;
            lc_exc_q      <= tc_exc_q;
            // updiscon is decoded from nc, so it enters at tc
            tc_updiscon_q <= nc_updiscon_i;
            lc_updiscon_q <= tc_updiscon_q;
        end
    end

    always_ff @(posedge clk_i) begin
        nc_pc_o        <= pc_i;
        nc_inst_o      <= inst_data_i;
        nc_priv_q      <= priv_lvl_i;
        nc_intr_q      <= interrupt_i;
        nc_cause_q     <= cause_i;
        tc_pc_o        <= nc_pc_o;
        tc_priv_o      <= nc_priv_q;
        tc_intr_q      <= nc_intr_q;
        tc_cause_q     <= nc_cause_q;
        lc_priv_q      <= tc_priv_o;
        lc_interrupt_o <= tc_intr_q;
        lc_cause_o     <= tc_cause_q;
    end

    assign tc_qualified_o    = tc_qual_q;
    // edges of the qualified window
    assign first_qualified_o = tc_qual_q && !lc_qual_q;
    assign final_qualified_o = tc_qual_q && !nc_qual_q;
    assign privchange_o      = tc_qual_q && lc_qual_q && (tc_priv_o != lc_priv_q);
    // lc flags only count when lc itself was traced
    assign lc_exception_o    = lc_qual_q && lc_exc_q;
    assign lc_updiscon_o     = lc_qual_q && lc_updiscon_q;

endmodule
